// ==== logic/pma_consts.svh ====
// PMA subsystem constants

`ifndef PMA_CONSTS_SVH
`define PMA_CONSTS_SVH

////////////////////
// Region set
////////////////////

// Number of attribute regions
`define PMA_CNT 4

////////////////////
// Widths
////////////////////

// Physical address width, XLEN equals PLEN
`define PMA_PLEN 32

// APB byte address width
`define PMA_APB_AW 8

`endif

// ==== logic/pma_pkg.sv ====
// PMA shared types

package pma_pkg;

  `include "pma_consts.svh"

  // Memory type of a region
  typedef enum logic [1:0] {
    MEM_EMPTY = 2'b00,
    MEM_MAIN  = 2'b01,
    MEM_IO    = 2'b10,
    MEM_TCM   = 2'b11
  } pma_mem_type_e;

  // Address matching mode
  typedef enum logic [1:0] {
    PMA_OFF   = 2'b00,
    PMA_TOR   = 2'b01,
    PMA_NA4   = 2'b10,
    PMA_NAPOT = 2'b11
  } pma_mode_e;

  // Transfer size, 1/2/4/8 bytes
  typedef enum logic [2:0] {
    SIZE_BYTE  = 3'b000,
    SIZE_HWORD = 3'b001,
    SIZE_WORD  = 3'b010,
    SIZE_DWORD = 3'b011
  } pma_size_e;

  // AMO field with no atomic support
  localparam logic [1:0] PMA_AMO_NONE = 2'b00;

  // 14-bit region configuration word
  typedef struct packed {
    pma_mem_type_e mem_type;
    logic          r;
    logic          w;
    logic          x;
    logic          cacheable;
    logic          cache_wb;
    logic          idempotent_rd;
    logic          idempotent_wr;
    logic          misalign_ok;
    logic [1:0]    amo;
    pma_mode_e     mode;
  } pma_cfg_t;

  // One physical access from the core stage
  typedef struct packed {
    logic                 valid;
    logic                 instr;
    logic                 we;
    logic [2:0]           size;
    logic                 misaligned;
    logic [`PMA_PLEN-1:0] adr;
  } pma_req_t;

  // Check result, one cycle after the request
  typedef struct packed {
    logic     valid;
    pma_cfg_t attr;
    logic     exception;
    logic     misaligned;
    logic     cache_acc;
    logic     ext_acc;
    logic     tcm_acc;
  } pma_rsp_t;

  // Region window in word addresses, lb inclusive, ub exclusive
  typedef struct packed {
    logic [`PMA_PLEN-3:0] lb;
    logic [`PMA_PLEN-3:0] ub;
  } pma_bound_t;

endpackage

// ==== logic/pma_regs.sv ====
// PMA register block

`timescale 1ns/1ps

`include "pma_consts.svh"

module pma_regs (
  input  logic                                   clk_i,
  input  logic                                   rst_i,
  // APB slave
  input  logic                                   psel_i,
  input  logic                                   penable_i,
  input  logic                                   pwrite_i,
  input  logic [`PMA_APB_AW-1:0]                 paddr_i,
  input  logic [`PMA_PLEN-1:0]                   pwdata_i,
  output logic [`PMA_PLEN-1:0]                   prdata_o,
  output logic                                   pready_o,
  output logic                                   pslverr_o,
  // Region state
  output pma_pkg::pma_cfg_t [`PMA_CNT-1:0]       cfg_o,
  output logic [`PMA_CNT-1:0][`PMA_PLEN-1:0]     adr_o
);

  localparam int IDX_W  = $clog2(`PMA_CNT);
  localparam int SLOT_W = `PMA_APB_AW - 3;
  localparam int CFG_W  = $bits(pma_pkg::pma_cfg_t);

  ////////////////////
  // Legalization
  ////////////////////

  function automatic pma_pkg::pma_cfg_t legalize(input pma_pkg::pma_cfg_t raw);
    pma_pkg::pma_cfg_t c;
    c = raw;
    // Empty slot, no access, shows up as io
    if (raw.mem_type == pma_pkg::MEM_EMPTY) begin
      c.mem_type = pma_pkg::MEM_IO;
      c.r        = 1'b0;
      c.w        = 1'b0;
      c.x        = 1'b0;
      c.amo      = pma_pkg::PMA_AMO_NONE;
    end
    // Caching only in main memory
    c.cacheable = raw.cacheable & (raw.mem_type == pma_pkg::MEM_MAIN);
    // Write-back needs a cacheable region
    c.cache_wb  = raw.cache_wb & c.cacheable;
    // Side effects only matter for io
    if (raw.mem_type != pma_pkg::MEM_IO) begin
      c.idempotent_rd = 1'b1;
      c.idempotent_wr = 1'b1;
    end
    return c;
  endfunction

  ////////////////////
  // Decode
  ////////////////////

  logic              access;
  logic              wr_en;
  logic              hit;
  logic              is_adr;
  logic [SLOT_W-1:0] slot;
  logic [IDX_W-1:0]  idx;

  pma_pkg::pma_cfg_t [`PMA_CNT-1:0]   cfg_q;
  logic [`PMA_CNT-1:0][`PMA_PLEN-1:0] adr_q;

  // Access phase of an APB transfer
  assign access = psel_i & penable_i;
  assign wr_en  = access & pwrite_i;

  // 8-byte slot per region
  assign slot   = paddr_i[`PMA_APB_AW-1:3];
  assign idx    = slot[IDX_W-1:0];
  // Offset +4 is the address word
  assign is_adr = paddr_i[2];
  // Word aligned and inside the region map
  assign hit    = (paddr_i[1:0] == 2'b00) && (slot < SLOT_W'(`PMA_CNT));

  ////////////////////
  // Storage
  ////////////////////

  // Writes land at the access-phase edge
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      // All regions OFF and empty
      for (int i = 0; i < `PMA_CNT; i++) begin
        cfg_q[i] <= '0;
        adr_q[i] <= '0;
      end
    end else if (wr_en && hit) begin
      if (is_adr) begin
        adr_q[idx] <= pwdata_i;
      end else begin
        cfg_q[idx] <= legalize(pma_pkg::pma_cfg_t'(pwdata_i[CFG_W-1:0]));
      end
    end
  end

  ////////////////////
  // Read and response
  ////////////////////

  // Read mux, zero off the map
  always_comb begin
    prdata_o = '0;
    if (hit) begin
      if (is_adr) begin
        prdata_o = adr_q[idx];
      end else begin
        prdata_o = {{(`PMA_PLEN-CFG_W){1'b0}}, cfg_q[idx]};
      end
    end
  end

  // No wait states
  assign pready_o  = access;
  // Unmapped or unaligned offsets error out
  assign pslverr_o = access & ~hit;

  assign cfg_o = cfg_q;
  assign adr_o = adr_q;

endmodule

// ==== logic/pma_bounds.sv ====
// PMA region bounds

`timescale 1ns/1ps

`include "pma_consts.svh"

module pma_bounds (
  input  pma_pkg::pma_cfg_t [`PMA_CNT-1:0]   cfg_i,
  input  logic [`PMA_CNT-1:0][`PMA_PLEN-1:0] adr_i,
  output pma_pkg::pma_bound_t [`PMA_CNT-1:0] bound_o
);

  // Word address width
  localparam int WA_W = `PMA_PLEN - 2;

  ////////////////////
  // NAPOT size
  ////////////////////

  // Run of ones from bit 0 upwards
  function automatic logic [5:0] ones_cnt(input logic [WA_W-1:0] w);
    logic [5:0] cnt;
    logic       run;
    int         b;
    cnt = '0;
    run = 1'b1;
    for (b = 0; b < WA_W; b++) begin
      run = run & w[b];
      cnt = cnt + {5'd0, run};
    end
    return cnt;
  endfunction

  ////////////////////
  // Per region
  ////////////////////

  for (genvar i = 0; i < `PMA_CNT; i++) begin : gen_rgn
    logic [WA_W-1:0] word;
    logic [WA_W-1:0] mask;
    logic [WA_W-1:0] tor_lb;
    logic [WA_W-1:0] lb;
    logic [WA_W-1:0] ub;
    logic [5:0]      n;

    assign word = adr_i[i][WA_W-1:0];

    // NA4 is one word, NAPOT is 2^(ones+1) words
    assign n    = (cfg_i[i].mode == pma_pkg::PMA_NA4) ? 6'd0 : ones_cnt(word) + 6'd1;
    assign mask = {WA_W{1'b1}} << n;

    // TOR starts where the previous region ends
    if (i == 0) begin : gen_first
      assign tor_lb = '0;
    end else begin : gen_chain
      assign tor_lb = (cfg_i[i-1].mode == pma_pkg::PMA_TOR) ? adr_i[i-1][WA_W-1:0]
                                                            : bound_o[i-1].ub;
    end

    always_comb begin
      case (cfg_i[i].mode)
        pma_pkg::PMA_TOR: begin
          lb = tor_lb;
          ub = word;
        end
        pma_pkg::PMA_NA4,
        pma_pkg::PMA_NAPOT: begin
          lb = word & mask;
          ub = (word + (WA_W'(1) << n)) & mask;
        end
        default: begin
          // OFF keeps the raw word as ub for a following TOR
          lb = '0;
          ub = word;
        end
      endcase
    end

    assign bound_o[i].lb = lb;
    assign bound_o[i].ub = ub;
  end

endmodule

// ==== logic/pma_check.sv ====
// PMA access checker

`timescale 1ns/1ps

`include "pma_consts.svh"

module pma_check (
  input  logic                                clk_i,
  input  logic                                rst_i,
  input  pma_pkg::pma_req_t                   req_i,
  input  pma_pkg::pma_cfg_t [`PMA_CNT-1:0]    cfg_i,
  input  pma_pkg::pma_bound_t [`PMA_CNT-1:0]  bound_i,
  output pma_pkg::pma_rsp_t                   rsp_o
);

  localparam int IDX_W = $clog2(`PMA_CNT);

  ////////////////////
  // Access span
  ////////////////////

  // Size code to byte count
  function automatic logic [`PMA_PLEN-1:0] size_bytes(input logic [2:0] size);
    case (size)
      pma_pkg::SIZE_BYTE:  return `PMA_PLEN'(1);
      pma_pkg::SIZE_HWORD: return `PMA_PLEN'(2);
      pma_pkg::SIZE_WORD:  return `PMA_PLEN'(4);
      pma_pkg::SIZE_DWORD: return `PMA_PLEN'(8);
      // Unknown codes act as a single byte
      default:             return `PMA_PLEN'(1);
    endcase
  endfunction

  logic [`PMA_PLEN-1:0] acc_lb;
  logic [`PMA_PLEN-1:0] acc_ub;
  logic [`PMA_CNT-1:0]  match_all;
  logic [IDX_W-1:0]     win_idx;
  pma_pkg::pma_cfg_t    win;
  pma_pkg::pma_rsp_t    rsp_d;
  logic                 fault;

  // First and last byte of the access
  assign acc_lb = req_i.adr;
  assign acc_ub = req_i.adr + size_bytes(req_i.size) - `PMA_PLEN'(1);

  ////////////////////
  // Match and priority
  ////////////////////

  // Every byte inside [lb, ub) of an enabled region
  for (genvar i = 0; i < `PMA_CNT; i++) begin : gen_match
    assign match_all[i] = (acc_lb[`PMA_PLEN-1:2] >= bound_i[i].lb) &&
                          (acc_ub[`PMA_PLEN-1:2] <  bound_i[i].ub) &&
                          (cfg_i[i].mode != pma_pkg::PMA_OFF);
  end

  // Lowest index wins, region 0 when nothing matches
  always_comb begin
    win_idx = '0;
    for (int i = `PMA_CNT - 1; i >= 0; i--) begin
      if (match_all[i]) begin
        win_idx = IDX_W'(i);
      end
    end
  end

  assign win = cfg_i[win_idx];

  ////////////////////
  // Result
  ////////////////////

  always_comb begin
    rsp_d.valid = req_i.valid;
    rsp_d.attr  = win;
    // No match or missing permission
    rsp_d.exception = req_i.valid & (~|match_all               |
                                     ( req_i.instr & ~win.x)   |
                                     ( req_i.we    & ~win.w)   |
                                     (~req_i.we    & ~win.r));
    rsp_d.misaligned = req_i.misaligned & ~win.misalign_ok;
    // Destination only for clean accesses
    fault = rsp_d.exception | rsp_d.misaligned;
    rsp_d.cache_acc = req_i.valid & ~fault & win.cacheable;
    rsp_d.tcm_acc   = req_i.valid & ~fault & (win.mem_type == pma_pkg::MEM_TCM);
    rsp_d.ext_acc   = req_i.valid & ~fault & ~win.cacheable &
                      (win.mem_type != pma_pkg::MEM_TCM);
  end

  // One cycle latency, new request every cycle
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      rsp_o <= '0;
    end else begin
      rsp_o <= rsp_d;
    end
  end

endmodule

// ==== logic/pma_unit.sv ====
// PMA check stage top

`timescale 1ns/1ps

`include "pma_consts.svh"

module pma_unit (
  input  logic                   clk_i,
  input  logic                   rst_i,
  // APB configuration port
  input  logic                   psel_i,
  input  logic                   penable_i,
  input  logic                   pwrite_i,
  input  logic [`PMA_APB_AW-1:0] paddr_i,
  input  logic [`PMA_PLEN-1:0]   pwdata_i,
  output logic [`PMA_PLEN-1:0]   prdata_o,
  output logic                   pready_o,
  output logic                   pslverr_o,
  // Check port
  input  pma_pkg::pma_req_t      req_i,
  output pma_pkg::pma_rsp_t      rsp_o
);

  // Region state from the register block
  pma_pkg::pma_cfg_t [`PMA_CNT-1:0]   cfg;
  logic [`PMA_CNT-1:0][`PMA_PLEN-1:0] adr;
  // Word-address windows
  pma_pkg::pma_bound_t [`PMA_CNT-1:0] bound;

  pma_regs u_regs (
    .clk_i     (clk_i),
    .rst_i     (rst_i),
    .psel_i    (psel_i),
    .penable_i (penable_i),
    .pwrite_i  (pwrite_i),
    .paddr_i   (paddr_i),
    .pwdata_i  (pwdata_i),
    .prdata_o  (prdata_o),
    .pready_o  (pready_o),
    .pslverr_o (pslverr_o),
    .cfg_o     (cfg),
    .adr_o     (adr)
  );

  pma_bounds u_bounds (
    .cfg_i   (cfg),
    .adr_i   (adr),
    .bound_o (bound)
  );

  pma_check u_check (
    .clk_i   (clk_i),
    .rst_i   (rst_i),
    .req_i   (req_i),
    .cfg_i   (cfg),
    .bound_i (bound),
    .rsp_o   (rsp_o)
  );

endmodule

// ==== dv/pma_scoreboard.sv ====
// PMA reference scoreboard

`timescale 1ns/1ps

`include "pma_consts.svh"

module pma_scoreboard (
  input  logic                   clk_i,
  input  logic                   rst_i,
  input  logic                   psel_i,
  input  logic                   penable_i,
  input  logic                   pwrite_i,
  input  logic [`PMA_APB_AW-1:0] paddr_i,
  input  logic [`PMA_PLEN-1:0]   pwdata_i,
  input  logic [`PMA_PLEN-1:0]   prdata_i,
  input  logic                   pready_i,
  input  logic                   pslverr_i,
  input  pma_pkg::pma_req_t      req_i,
  input  pma_pkg::pma_rsp_t      rsp_i,
  input  logic [2:0]             test_id_i,
  input  logic                   test_end_i,
  output int                     err_total_o
);

  // Shadow copy of the region registers
  pma_pkg::pma_cfg_t    m_cfg [`PMA_CNT];
  logic [`PMA_PLEN-1:0] m_adr [`PMA_CNT];
  logic [29:0]          m_lb  [`PMA_CNT];
  logic [29:0]          m_ub  [`PMA_CNT];

  pma_pkg::pma_rsp_t exp_rsp;
  logic              have_exp;
  logic              mapped;
  int                checks;
  int                errs;
  int                errs_total;
  int                tests_failed;

  assign err_total_o = errs_total;

  function automatic string test_name(input logic [2:0] id);
    case (id)
      3'd0:    return "reset_state";
      3'd1:    return "cfg_readback";
      3'd2:    return "napot_na4";
      3'd3:    return "tor_straddle";
      3'd4:    return "priority";
      default: return "misalign_dest";
    endcase
  endfunction

  task automatic fail_val(input string what, input logic [63:0] exp, input logic [63:0] act);
    $display("[FAIL] %s %s: expected %h, actual %h", test_name(test_id_i), what, exp, act);
    errs++;
    errs_total++;
  endtask

  ////////////////////
  // Reference model
  ////////////////////

  // Configuration word as stored after a write
  function automatic pma_pkg::pma_cfg_t legal_model(input logic [13:0] raw);
    pma_pkg::pma_cfg_t c;
    logic              was_main;
    logic              was_io;
    c        = pma_pkg::pma_cfg_t'(raw);
    was_main = (raw[13:12] == 2'b01);
    was_io   = (raw[13:12] == 2'b10);
    if (raw[13:12] == 2'b00) begin
      c.mem_type = pma_pkg::MEM_IO;
      c.r        = 1'b0;
      c.w        = 1'b0;
      c.x        = 1'b0;
      c.amo      = 2'b00;
    end
    if (!was_main) c.cacheable = 1'b0;
    if (!c.cacheable) c.cache_wb = 1'b0;
    if (!was_io) begin
      c.idempotent_rd = 1'b1;
      c.idempotent_wr = 1'b1;
    end
    return c;
  endfunction

  // Window of every region in word addresses
  task automatic calc_bounds();
    logic [29:0] w;
    logic [29:0] span;
    int          n;
    for (int i = 0; i < `PMA_CNT; i++) begin
      w = m_adr[i][29:0];
      case (m_cfg[i].mode)
        pma_pkg::PMA_TOR: begin
          if (i == 0) m_lb[i] = '0;
          else if (m_cfg[i-1].mode == pma_pkg::PMA_TOR) m_lb[i] = m_adr[i-1][29:0];
          else m_lb[i] = m_ub[i-1];
          m_ub[i] = w;
        end
        pma_pkg::PMA_NA4, pma_pkg::PMA_NAPOT: begin
          n = 0;
          if (m_cfg[i].mode == pma_pkg::PMA_NAPOT) begin
            // Trailing ones plus one
            while (n < 30 && w[n]) n++;
            n++;
          end
          span    = 30'(1) << n;
          m_lb[i] = w & ~(span - 30'(1));
          m_ub[i] = (w + span) & ~(span - 30'(1));
        end
        default: begin
          m_lb[i] = '0;
          m_ub[i] = w;
        end
      endcase
    end
  endtask

  function automatic pma_pkg::pma_rsp_t predict(input pma_pkg::pma_req_t rq);
    pma_pkg::pma_rsp_t r;
    logic [31:0]       last;
    logic              found;
    logic              fault;
    int                win;
    found = 1'b0;
    win   = 0;
    last  = rq.adr + ((rq.size < 3'd4) ? (32'(1) << rq.size) : 32'(1)) - 32'(1);
    for (int i = 0; i < `PMA_CNT; i++) begin
      if (!found && m_cfg[i].mode != pma_pkg::PMA_OFF &&
          rq.adr[31:2] >= m_lb[i] && last[31:2] < m_ub[i]) begin
        found = 1'b1;
        win   = i;
      end
    end
    r.valid      = rq.valid;
    r.attr       = m_cfg[win];
    r.exception  = rq.valid & (!found | (rq.instr & !r.attr.x) |
                               (rq.we & !r.attr.w) | (!rq.we & !r.attr.r));
    r.misaligned = rq.misaligned & !r.attr.misalign_ok;
    fault        = r.exception | r.misaligned;
    r.cache_acc  = rq.valid & !fault & r.attr.cacheable;
    r.tcm_acc    = rq.valid & !fault & (r.attr.mem_type == pma_pkg::MEM_TCM);
    r.ext_acc    = rq.valid & !fault & !r.attr.cacheable &
                   (r.attr.mem_type != pma_pkg::MEM_TCM);
    return r;
  endfunction

  ////////////////////
  // Compare
  ////////////////////

  initial begin
    checks       = 0;
    errs         = 0;
    errs_total   = 0;
    tests_failed = 0;
    have_exp     = 1'b0;
    exp_rsp      = '0;
  end

  always @(posedge clk_i) begin
    if (rst_i) begin
      for (int i = 0; i < `PMA_CNT; i++) begin
        m_cfg[i] = '0;
        m_adr[i] = '0;
      end
      // Quiet APB and a cleared response right out of reset
      if (pready_i !== 1'b0) fail_val("pready", 64'(0), 64'(pready_i));
      if (pslverr_i !== 1'b0) fail_val("pslverr", 64'(0), 64'(pslverr_i));
      exp_rsp  = '0;
      have_exp = 1'b1;
    end else begin
      // Response to the request seen one edge earlier
      if (have_exp) begin
        checks++;
        if (rsp_i !== exp_rsp) fail_val("rsp", 64'(exp_rsp), 64'(rsp_i));
      end
      calc_bounds();
      exp_rsp  = predict(req_i);
      have_exp = 1'b1;
      // APB access phase
      if (psel_i && penable_i) begin
        mapped = (paddr_i[1:0] == 2'b00) && (paddr_i[7:3] < 5'(`PMA_CNT));
        checks++;
        if (pready_i !== 1'b1) fail_val("pready", 64'(1), 64'(pready_i));
        if (pslverr_i !== !mapped) fail_val("pslverr", 64'(!mapped), 64'(pslverr_i));
        if (!pwrite_i) begin
          if (!mapped) begin
            if (prdata_i !== '0) fail_val("prdata", 64'(0), 64'(prdata_i));
          end else if (paddr_i[2]) begin
            if (prdata_i !== m_adr[paddr_i[4:3]])
              fail_val("prdata", 64'(m_adr[paddr_i[4:3]]), 64'(prdata_i));
          end else if (prdata_i !== {18'd0, m_cfg[paddr_i[4:3]]}) begin
            fail_val("prdata", 64'(m_cfg[paddr_i[4:3]]), 64'(prdata_i));
          end
        end else if (mapped) begin
          if (paddr_i[2]) m_adr[paddr_i[4:3]] = pwdata_i;
          else m_cfg[paddr_i[4:3]] = legal_model(pwdata_i[13:0]);
        end
      end
      // Per-test line and the closing line after the last test
      if (test_end_i) begin
        $display("%s: %s (%0d checks, %0d errors)", test_name(test_id_i),
                 (errs == 0) ? "pass" : "fail", checks, errs);
        if (errs != 0) tests_failed++;
        checks = 0;
        errs   = 0;
        if (test_id_i == 3'd5)
          $display("Summary: 6 tests, %0d failed, %0d errors", tests_failed, errs_total);
      end
    end
  end

endmodule

// ==== dv/pma_unit_tb.sv ====
// PMA unit testbench

`timescale 1ns/1ps

`include "pma_consts.svh"

module pma_unit_tb;

  // Planned cycles of all tests including reset
  localparam int PLAN_CYC = 560;
  localparam int LIMIT    = 4 * PLAN_CYC;

  logic                   clk_i;
  logic                   rst_i;
  logic                   psel_i;
  logic                   penable_i;
  logic                   pwrite_i;
  logic [`PMA_APB_AW-1:0] paddr_i;
  logic [`PMA_PLEN-1:0]   pwdata_i;
  logic [`PMA_PLEN-1:0]   prdata_o;
  logic                   pready_o;
  logic                   pslverr_o;
  pma_pkg::pma_req_t      req_i;
  pma_pkg::pma_rsp_t      rsp_o;
  logic [2:0]             test_id;
  logic                   test_end;
  int                     err_total;
  int                     cyc;
  logic [31:0]            lfsr_q;
  logic [31:0]            v;
  logic [31:0]            bnd;

  pma_unit UUT (.*);

  pma_scoreboard u_sb (
    .clk_i (clk_i), .rst_i (rst_i), .psel_i (psel_i), .penable_i (penable_i),
    .pwrite_i (pwrite_i), .paddr_i (paddr_i), .pwdata_i (pwdata_i),
    .prdata_i (prdata_o), .pready_i (pready_o), .pslverr_i (pslverr_o),
    .req_i (req_i), .rsp_i (rsp_o), .test_id_i (test_id), .test_end_i (test_end),
    .err_total_o (err_total)
  );

  initial begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  // Run limit
  always @(posedge clk_i) begin
    cyc <= cyc + 1;
    if (cyc > LIMIT) begin
      $display("Timeout: run did not finish within %0d cycles", LIMIT);
      $display("*** TEST FAILED ***");
      $finish;
    end
  end

  ////////////////////
  // Stimulus helpers
  ////////////////////

  // Taps 32, 22, 2, 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic rand_bits(input int n, output logic [31:0] r);
    r = '0;
    for (int k = 0; k < n; k++) begin
      lfsr_q = lfsr_next(lfsr_q);
      r      = {r[30:0], lfsr_q[0]};
    end
  endtask

  task automatic apb_access(input logic wr, input logic [7:0] addr, input logic [31:0] data);
    @(posedge clk_i);
    psel_i   <= 1'b1;
    penable_i <= 1'b0;
    pwrite_i <= wr;
    paddr_i  <= addr;
    pwdata_i <= data;
    @(posedge clk_i);
    penable_i <= 1'b1;
    @(posedge clk_i);
    psel_i    <= 1'b0;
    penable_i <= 1'b0;
  endtask

  task automatic set_region(input int i, input logic [13:0] cfg, input logic [31:0] adr);
    apb_access(1'b1, 8'(8 * i), {18'd0, cfg});
    apb_access(1'b1, 8'(8 * i + 4), adr);
  endtask

  // Random cfg bits above a fixed mode
  function automatic logic [13:0] cfg_with(input logic [31:0] r, input logic [1:0] mode);
    return {r[11:0], mode};
  endfunction

  task automatic send_req(input logic [31:0] adr, input logic mis);
    logic [31:0] r;
    rand_bits(4, r);
    @(posedge clk_i);
    req_i.valid      <= 1'b1;
    req_i.instr      <= r[3];
    req_i.we         <= r[2];
    req_i.size       <= {1'b0, r[1:0]};
    req_i.misaligned <= mis;
    req_i.adr        <= adr;
  endtask

  task automatic begin_test(input logic [2:0] id);
    @(posedge clk_i);
    test_id <= id;
  endtask

  // Drain the pipeline and then flag the end
  task automatic end_test();
    @(posedge clk_i);
    req_i <= '0;
    repeat (2) @(posedge clk_i);
    test_end <= 1'b1;
    @(posedge clk_i);
    test_end <= 1'b0;
  endtask

  ////////////////////
  // Tests
  ////////////////////

  initial begin
    rst_i     = 1'b1;
    psel_i    = 1'b0;
    penable_i = 1'b0;
    pwrite_i  = 1'b0;
    paddr_i   = '0;
    pwdata_i  = '0;
    req_i     = '0;
    test_id   = '0;
    test_end  = 1'b0;
    cyc       = 0;
    lfsr_q    = 32'h18ef;
    repeat (8) @(posedge clk_i);
    rst_i <= 1'b0;

    // Everything faults out of reset
    begin_test(3'd0);
    for (int k = 0; k < 32; k++) begin
      rand_bits(32, v);
      send_req(v, 1'b0);
    end
    end_test();

    // Legalized readback and unmapped offsets
    begin_test(3'd1);
    for (int i = 0; i < `PMA_CNT; i++) begin
      rand_bits(32, v);
      apb_access(1'b1, 8'(8 * i), v);
      rand_bits(32, v);
      apb_access(1'b1, 8'(8 * i + 4), v);
      apb_access(1'b0, 8'(8 * i), '0);
      apb_access(1'b0, 8'(8 * i + 4), '0);
    end
    apb_access(1'b1, 8'h20, 32'hffff_ffff);
    apb_access(1'b0, 8'h20, '0);
    apb_access(1'b0, 8'h40, '0);
    end_test();

    // NAPOT 4K at 0x1000, NA4 at 0x2000, NAPOT 256 at 0x2000
    begin_test(3'd2);
    rand_bits(12, v);
    set_region(0, cfg_with(v, 2'b11), 32'h0000_05ff);
    rand_bits(12, v);
    set_region(1, cfg_with(v, 2'b10), 32'h0000_0800);
    rand_bits(12, v);
    set_region(2, cfg_with(v, 2'b11), 32'h0000_081f);
    set_region(3, 14'd0, 32'd0);
    for (int k = 0; k < 64; k++) begin
      rand_bits(14, v);
      // Half the accesses land near the small regions at 0x2000
      if (k % 4 == 1) v = 32'h1ffc + {28'd0, v[3:0]};
      else if (k % 4 == 3) v = 32'h1ff8 + {23'd0, v[8:0]};
      send_req(v, 1'b0);
    end
    end_test();

    // TOR regions after a NAPOT one with accesses around every bound
    begin_test(3'd3);
    rand_bits(12, v);
    set_region(0, cfg_with(v, 2'b11), 32'h0000_05ff);
    rand_bits(12, v);
    set_region(1, cfg_with(v, 2'b01), 32'h0000_1000);
    rand_bits(12, v);
    set_region(2, cfg_with(v, 2'b01), 32'h0000_1400);
    rand_bits(12, v);
    set_region(3, cfg_with(v, 2'b10), 32'h0000_1800);
    for (int k = 0; k < 64; k++) begin
      rand_bits(3, v);
      case (v[2:0])
        3'd0:    bnd = 32'h1000;
        3'd1:    bnd = 32'h2000;
        3'd2:    bnd = 32'h4000;
        3'd3:    bnd = 32'h5000;
        default: bnd = 32'h6000;
      endcase
      rand_bits(4, v);
      send_req(bnd - 32'd8 + v, 1'b0);
    end
    end_test();

    // Overlapping regions where the lowest index wins
    begin_test(3'd4);
    rand_bits(12, v);
    set_region(0, cfg_with(v, 2'b10), 32'h0000_0440);
    rand_bits(12, v);
    set_region(1, cfg_with(v, 2'b11), 32'h0000_05ff);
    rand_bits(12, v);
    set_region(2, cfg_with(v, 2'b11), 32'h0000_07ff);
    rand_bits(12, v);
    set_region(3, cfg_with(v, 2'b01), 32'h0000_2000);
    for (int k = 0; k < 64; k++) begin
      rand_bits(15, v);
      // Every fourth access sits around the NA4 word at 0x1100
      if (k % 4 == 0) v = 32'h10f8 + {28'd0, v[3:0]};
      send_req(v, 1'b0);
    end
    end_test();

    // One 64K region swept over every memory type
    begin_test(3'd5);
    for (int i = 1; i < `PMA_CNT; i++) begin
      apb_access(1'b1, 8'(8 * i), '0);
    end
    for (int t = 0; t < 4; t++) begin
      rand_bits(6, v);
      set_region(0, {2'(t), 3'b111, v[5:4], v[3:2], v[1], 2'b00, 2'b11}, 32'h0000_1fff);
      for (int k = 0; k < 32; k++) begin
        rand_bits(17, v);
        send_req({16'd0, v[15:0]}, v[16]);
      end
    end
    end_test();

    // Let the compares of the last edge settle
    @(negedge clk_i);
    if (err_total != 0) begin
      $display("*** TEST FAILED ***");
    end else begin
      $display("*** TEST PASSED ***");
    end
    $finish;
  end

endmodule

// ==== pma_unit.f ====
+incdir+logic
logic/pma_pkg.sv
logic/pma_regs.sv
logic/pma_bounds.sv
logic/pma_check.sv
logic/pma_unit.sv
dv/pma_scoreboard.sv
dv/pma_unit_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build with Verilator, run, and look for the pass line

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f pma_unit.f --top-module pma_unit_tb -o pma_sim \
  && ./obj_dir/pma_sim | tee /dev/stderr | grep -qF '*** TEST PASSED ***' \
  && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }
